// ==== include/mpdma_cfg.svh ====
/*
 * Build-time configuration macros for the matrix-padding DMA engine:
 * bus widths, width-field size, word stride and largest matrix width
 */

`ifndef MPDMA_CFG_SVH
`define MPDMA_CFG_SVH

// Memory bus
`define MPDMA_ADDR_W        32
`define MPDMA_DATA_W        32

// Matrix width field from software, even values 2..62
`define MPDMA_WIDTH_BITS    6
`define MPDMA_MAX_WIDTH     62

// Byte stride between consecutive words
`define MPDMA_WORD_BYTES    4

`endif

// ==== source/mpdma_pkg.sv ====
/*
 * Shared types of the matrix-padding DMA engine: address and data
 * words, matrix dimension, 2x2 block position and walker state
 */

`default_nettype none

`include "mpdma_cfg.svh"

package mpdma_pkg;

    typedef logic [`MPDMA_ADDR_W-1:0] addr_t;
    typedef logic [`MPDMA_DATA_W-1:0] data_t;

    // One bit above the width field so W+1 fits
    typedef logic [`MPDMA_WIDTH_BITS:0] dim_t;

    // Bit 1 selects the lower row, bit 0 the right column
    typedef enum logic [1:0] {
        QUAD_TL = 2'd0,
        QUAD_TR = 2'd1,
        QUAD_BL = 2'd2,
        QUAD_BR = 2'd3
    } quad_e;

    typedef enum logic [1:0] {
        WALK_IDLE  = 2'd0,
        WALK_RUN   = 2'd1,  // Jobs still to issue
        WALK_DRAIN = 2'd2,  // All issued, waiting on writes
        WALK_DONE  = 2'd3
    } walk_state_e;

endpackage

`default_nettype wire

// ==== source/mpdma_job_if.sv ====
/*
 * Word-copy job channel from the block walker to the read master,
 * valid/ready with source and destination addresses
 */

`default_nettype none

interface mpdma_job_if;

    logic             valid;
    logic             ready;
    mpdma_pkg::addr_t src_addr;   // Word to fetch
    mpdma_pkg::addr_t dst_addr;   // Where it lands in the padded matrix

    modport walker (
        output valid,
        output src_addr,
        output dst_addr,
        input  ready
    );

    modport reader (
        input  valid,
        input  src_addr,
        input  dst_addr,
        output ready
    );

endinterface

`default_nettype wire

// ==== source/mpdma_word_if.sv ====
/*
 * Fetched-word channel from the read master to the write master,
 * valid/ready with data and destination address
 */

`default_nettype none

interface mpdma_word_if;

    logic             valid;
    logic             ready;
    mpdma_pkg::data_t data;
    mpdma_pkg::addr_t dst_addr;

    // Read side offers the word
    modport reader (
        output valid,
        output data,
        output dst_addr,
        input  ready
    );

    modport writer (
        input  valid,
        input  data,
        input  dst_addr,
        output ready
    );

endinterface

`default_nettype wire

// ==== source/mpdma_block_walker.sv ====
/*
 * Start/done control and 2x2 block walk of the padded output matrix,
 * mirror mapping to source positions, job address generation and
 * completion counting
 */

`default_nettype none

`include "mpdma_cfg.svh"

module mpdma_block_walker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire mpdma_pkg::addr_t        src_addr_i,
    input  wire mpdma_pkg::addr_t        dst_addr_i,
    input  wire [`MPDMA_WIDTH_BITS-1:0]  mat_width_i,
    input  wire                          start_i,
    output logic                         done_o,
    input  wire                          wr_done_i,
    mpdma_job_if.walker                  job
);

    // Enough for (W+2)^2 at the largest width
    localparam int CNT_W = $clog2((`MPDMA_MAX_WIDTH + 2) * (`MPDMA_MAX_WIDTH + 2) + 1);

    mpdma_pkg::walk_state_e state;
    mpdma_pkg::quad_e       quad;
    mpdma_pkg::dim_t        blk_row;
    mpdma_pkg::dim_t        blk_col;

    // Configuration captured at start
    mpdma_pkg::addr_t       src_base;
    mpdma_pkg::addr_t       dst_base;
    mpdma_pkg::dim_t        width;
    logic [CNT_W-1:0]       total_cnt;

    logic [CNT_W-1:0]       issue_cnt;
    logic [CNT_W-1:0]       done_cnt;
    logic [CNT_W-1:0]       done_cnt_nxt;

    mpdma_pkg::dim_t        out_row;
    mpdma_pkg::dim_t        out_col;
    mpdma_pkg::dim_t        src_row;
    mpdma_pkg::dim_t        src_col;
    mpdma_pkg::dim_t        dst_span;
    mpdma_pkg::dim_t        start_span;
    mpdma_pkg::addr_t       src_idx;
    mpdma_pkg::addr_t       dst_idx;
    logic                   start_go;
    logic                   job_fire;

    // Border rows and columns reflect about the first or last source line
    function automatic mpdma_pkg::dim_t mirror_idx(input mpdma_pkg::dim_t k,
                                                   input mpdma_pkg::dim_t w);
        if (k == 0) begin
            mirror_idx = mpdma_pkg::dim_t'(1);
        end else if (k == w + 1) begin
            mirror_idx = mpdma_pkg::dim_t'(w - 2);
        end else begin
            mirror_idx = mpdma_pkg::dim_t'(k - 1);
        end
    endfunction

    assign out_row  = blk_row + mpdma_pkg::dim_t'(quad[1]);
    assign out_col  = blk_col + mpdma_pkg::dim_t'(quad[0]);
    assign src_row  = mirror_idx(out_row, width);
    assign src_col  = mirror_idx(out_col, width);
    assign dst_span = width + mpdma_pkg::dim_t'(2);

    assign src_idx = mpdma_pkg::addr_t'(src_row) * mpdma_pkg::addr_t'(width)
                   + mpdma_pkg::addr_t'(src_col);
    assign dst_idx = mpdma_pkg::addr_t'(out_row) * mpdma_pkg::addr_t'(dst_span)
                   + mpdma_pkg::addr_t'(out_col);

    assign job.valid    = (state == mpdma_pkg::WALK_RUN);
    assign job.src_addr = src_base + src_idx * `MPDMA_WORD_BYTES;
    assign job.dst_addr = dst_base + dst_idx * `MPDMA_WORD_BYTES;

    assign job_fire     = job.valid & job.ready;
    assign start_go     = (state == mpdma_pkg::WALK_IDLE) & start_i;
    assign start_span   = mpdma_pkg::dim_t'(mat_width_i) + mpdma_pkg::dim_t'(2);
    assign done_cnt_nxt = done_cnt + CNT_W'(wr_done_i);
    assign done_o       = (state == mpdma_pkg::WALK_IDLE) | (state == mpdma_pkg::WALK_DONE);

    always_ff @(posedge clk) begin
        if (start_go) begin
            src_base  <= src_addr_i;
            dst_base  <= dst_addr_i;
            width     <= mpdma_pkg::dim_t'(mat_width_i);
            total_cnt <= CNT_W'(start_span) * CNT_W'(start_span);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mpdma_pkg::WALK_IDLE;
            quad      <= mpdma_pkg::QUAD_TL;
            blk_row   <= '0;
            blk_col   <= '0;
            issue_cnt <= '0;
            done_cnt  <= '0;
        end else begin
            case (state)
                mpdma_pkg::WALK_IDLE: begin
                    if (start_i) begin
                        state     <= mpdma_pkg::WALK_RUN;
                        quad      <= mpdma_pkg::QUAD_TL;
                        blk_row   <= '0;
                        blk_col   <= '0;
                        issue_cnt <= '0;
                        done_cnt  <= '0;
                    end
                end
                mpdma_pkg::WALK_RUN: begin
                    done_cnt <= done_cnt_nxt;
                    if (job_fire) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (issue_cnt == total_cnt - 1'b1) begin
                            state <= mpdma_pkg::WALK_DRAIN;
                        end
                        if (quad != mpdma_pkg::QUAD_BR) begin
                            quad <= mpdma_pkg::quad_e'(quad + 2'd1);
                        end else begin
                            quad <= mpdma_pkg::QUAD_TL;
                            if (blk_col == width) begin  // Last block of the row
                                blk_col <= '0;
                                blk_row <= blk_row + mpdma_pkg::dim_t'(2);
                            end else begin
                                blk_col <= blk_col + mpdma_pkg::dim_t'(2);
                            end
                        end
                    end
                end
                mpdma_pkg::WALK_DRAIN: begin
                    done_cnt <= done_cnt_nxt;
                    if (done_cnt_nxt == total_cnt) begin
                        state <= mpdma_pkg::WALK_DONE;
                    end
                end
                mpdma_pkg::WALK_DONE: begin
                    if (!start_i) begin  // Rearm only after start drops
                        state <= mpdma_pkg::WALK_IDLE;
                    end
                end
                default: state <= mpdma_pkg::WALK_IDLE;
            endcase
        end
    end

    // A write completion outside a run means a lost or duplicated job
    a_no_stray_done: assert property (@(posedge clk) disable iff (!rst_n)
        wr_done_i |-> (state == mpdma_pkg::WALK_RUN || state == mpdma_pkg::WALK_DRAIN));

endmodule

`default_nettype wire

// ==== source/mpdma_read_master.sv ====
/*
 * Single-beat AR/R read engine, one read per job, with a one-word
 * holding register toward the write master
 */

`default_nettype none

module mpdma_read_master (
    input  wire                    clk,
    input  wire                    rst_n,
    mpdma_job_if.reader            job,
    mpdma_word_if.reader           word,
    output mpdma_pkg::addr_t       araddr_o,
    output logic                   arvalid_o,
    input  wire                    arready_i,
    input  wire mpdma_pkg::data_t  rdata_i,
    input  wire                    rvalid_i,
    output logic                   rready_o
);

    logic             ar_valid;
    logic             r_ready;
    logic             hold_valid;
    mpdma_pkg::addr_t ar_addr;
    mpdma_pkg::addr_t hold_dst;
    mpdma_pkg::data_t hold_data;
    logic             job_fire;
    logic             ar_fire;
    logic             r_fire;
    logic             word_fire;

    assign ar_fire   = ar_valid & arready_i;
    assign r_fire    = r_ready & rvalid_i;
    assign word_fire = hold_valid & word.ready;

    // Free when no read is open and the held word is gone or leaving now
    assign job.ready = ~(ar_valid | r_ready) & (~hold_valid | word.ready);
    assign job_fire  = job.valid & job.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (job_fire) begin
                ar_valid <= 1'b1;
            end else if (ar_fire) begin
                ar_valid <= 1'b0;
                r_ready  <= 1'b1;  // Address taken, wait for data
            end
            if (r_fire) begin
                r_ready    <= 1'b0;
                hold_valid <= 1'b1;
            end else if (word_fire) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_fire) begin
            ar_addr  <= job.src_addr;
            hold_dst <= job.dst_addr;  // Travels with the word
        end
        if (r_fire) begin
            hold_data <= rdata_i;
        end
    end

    assign araddr_o      = ar_addr;
    assign arvalid_o     = ar_valid;
    assign rready_o      = r_ready;
    assign word.valid    = hold_valid;
    assign word.data     = hold_data;
    assign word.dst_addr = hold_dst;

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

endmodule

`default_nettype wire

// ==== source/mpdma_write_master.sv ====
/*
 * Single-beat AW/W/B write engine with independent address and data
 * channels and a completion pulse per accepted response
 */

`default_nettype none

module mpdma_write_master (
    input  wire                    clk,
    input  wire                    rst_n,
    mpdma_word_if.writer           word,
    output mpdma_pkg::addr_t       awaddr_o,
    output logic                   awvalid_o,
    input  wire                    awready_i,
    output mpdma_pkg::data_t       wdata_o,
    output logic                   wvalid_o,
    input  wire                    wready_i,
    input  wire                    bvalid_i,
    output logic                   bready_o,
    output logic                   wr_done_o
);

    logic             aw_valid;
    logic             w_valid;
    logic             b_ready;
    logic             wr_done;
    mpdma_pkg::addr_t aw_addr;
    mpdma_pkg::data_t w_data;
    logic             word_fire;
    logic             aw_left;
    logic             w_left;
    logic             b_fire;

    // Busy from word accept until the response is taken
    assign word.ready = ~(aw_valid | w_valid | b_ready);
    assign word_fire  = word.valid & word.ready;

    // Channels still open after this edge
    assign aw_left = aw_valid & ~awready_i;
    assign w_left  = w_valid & ~wready_i;
    assign b_fire  = b_ready & bvalid_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
            wr_done  <= 1'b0;
        end else begin
            wr_done <= b_fire;
            if (word_fire) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
            end else begin
                aw_valid <= aw_left;
                w_valid  <= w_left;
            end
            if ((aw_valid | w_valid) & ~aw_left & ~w_left) begin
                b_ready <= 1'b1;  // Both halves sent
            end else if (b_fire) begin
                b_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_fire) begin
            aw_addr <= word.dst_addr;
            w_data  <= word.data;
        end
    end

    assign awaddr_o  = aw_addr;
    assign awvalid_o = aw_valid;
    assign wdata_o   = w_data;
    assign wvalid_o  = w_valid;
    assign bready_o  = b_ready;
    assign wr_done_o = wr_done;

    a_b_after_aw_w: assert property (@(posedge clk) disable iff (!rst_n)
        bready_o |-> !awvalid_o && !wvalid_o);

endmodule

`default_nettype wire

// ==== source/mpdma_top.sv ====
/*
 * Matrix-padding DMA top level with plain memory ports, joining the
 * walker, read master and write master
 */

`default_nettype none

`include "mpdma_cfg.svh"

module mpdma_top (
    input  wire                          clk,
    input  wire                          rst_n,

    // Software configuration
    input  wire mpdma_pkg::addr_t        src_addr_i,
    input  wire mpdma_pkg::addr_t        dst_addr_i,
    input  wire [`MPDMA_WIDTH_BITS-1:0]  mat_width_i,
    input  wire                          start_i,
    output logic                         done_o,

    // Read address and data
    output mpdma_pkg::addr_t             araddr_o,
    output logic                         arvalid_o,
    input  wire                          arready_i,
    input  wire mpdma_pkg::data_t        rdata_i,
    input  wire                          rvalid_i,
    output logic                         rready_o,

    // Write address, data and response
    output mpdma_pkg::addr_t             awaddr_o,
    output logic                         awvalid_o,
    input  wire                          awready_i,
    output mpdma_pkg::data_t             wdata_o,
    output logic                         wvalid_o,
    input  wire                          wready_i,
    input  wire                          bvalid_i,
    output logic                         bready_o
);

    logic wr_done;  // One pulse per B response

    mpdma_job_if  u_job_if ();
    mpdma_word_if u_word_if ();

    mpdma_block_walker u_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .start_i     (start_i),
        .done_o      (done_o),
        .wr_done_i   (wr_done),
        .job         (u_job_if.walker)
    );

    mpdma_read_master u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .job       (u_job_if.reader),
        .word      (u_word_if.reader),
        .araddr_o  (araddr_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o)
    );

    mpdma_write_master u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .word      (u_word_if.writer),
        .awaddr_o  (awaddr_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o),
        .wr_done_o (wr_done)
    );

endmodule

`default_nettype wire

// ==== tb/mpdma_mem_model.sv ====
/*
 * Memory model for the DMA testbench: single-beat read and write ports,
 * random ready/valid stalls, source fill and an ordered log of writes
 */

`default_nettype none

module mpdma_mem_model (
    input  wire                    clk,
    input  wire                    rst_n,
    input  int                     stall_pct_i,   // Chance of a stall per beat
    input  wire mpdma_pkg::addr_t  araddr_i,
    input  wire                    arvalid_i,
    output logic                   arready_o,
    output mpdma_pkg::data_t       rdata_o,
    output logic                   rvalid_o,
    input  wire                    rready_i,
    input  wire mpdma_pkg::addr_t  awaddr_i,
    input  wire                    awvalid_i,
    output logic                   awready_o,
    input  wire mpdma_pkg::data_t  wdata_i,
    input  wire                    wvalid_i,
    output logic                   wready_o,
    output logic                   bvalid_o,
    input  wire                    bready_i
);

    mpdma_pkg::data_t mem [mpdma_pkg::addr_t];
    mpdma_pkg::addr_t wr_addr_log [$];
    mpdma_pkg::data_t wr_data_log [$];

    logic             ar_ready = 1'b0;
    logic             r_valid  = 1'b0;
    logic             aw_ready = 1'b0;
    logic             w_ready  = 1'b0;
    logic             b_valid  = 1'b0;
    mpdma_pkg::data_t r_data   = '0;
    mpdma_pkg::addr_t rd_addr  = '0;
    mpdma_pkg::addr_t aw_addr_q = '0;
    mpdma_pkg::data_t w_data_q = '0;
    logic             rd_pend  = 1'b0;   // Read address taken, data not yet
    logic             aw_have  = 1'b0;
    logic             w_have   = 1'b0;
    logic             b_pend   = 1'b0;
    logic             got_aw;
    logic             got_w;

    function automatic bit beat_allowed(input int pct);
        return int'($urandom % 32'd100) >= pct;
    endfunction

    // Unwritten words read back as an address-dependent pattern
    function automatic mpdma_pkg::data_t peek(input mpdma_pkg::addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'hA5A5_5A5A);
    endfunction

    task automatic fill_source(input mpdma_pkg::addr_t base, input int width);
        for (int i = 0; i < width * width; i++) begin
            mem[base + mpdma_pkg::addr_t'(i * 4)] = $urandom;
        end
    endtask

    task automatic clear_log();
        wr_addr_log.delete();
        wr_data_log.delete();
    endtask

    function automatic int log_size();
        return wr_addr_log.size();
    endfunction

    function automatic mpdma_pkg::addr_t log_addr(input int i);
        return wr_addr_log[i];
    endfunction

    function automatic mpdma_pkg::data_t log_data(input int i);
        return wr_data_log[i];
    endfunction

    // Handshakes are sampled on the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            if (arvalid_i && ar_ready) begin
                rd_addr <= araddr_i;
                rd_pend <= 1'b1;
            end else if (r_valid && rready_i) begin
                rd_pend <= 1'b0;
            end
            got_aw = aw_have || (awvalid_i && aw_ready);
            got_w  = w_have || (wvalid_i && w_ready);
            if (got_aw && got_w) begin  // Both halves here, commit the word
                mem[aw_have ? aw_addr_q : awaddr_i] = w_have ? w_data_q : wdata_i;
                wr_addr_log.push_back(aw_have ? aw_addr_q : awaddr_i);
                wr_data_log.push_back(w_have ? w_data_q : wdata_i);
                aw_have <= 1'b0;
                w_have  <= 1'b0;
                b_pend  <= 1'b1;
            end else begin
                if (awvalid_i && aw_ready) begin
                    aw_addr_q <= awaddr_i;
                    aw_have   <= 1'b1;
                end
                if (wvalid_i && w_ready) begin
                    w_data_q <= wdata_i;
                    w_have   <= 1'b1;
                end
            end
            if (b_valid && bready_i) begin
                b_pend <= 1'b0;
            end
        end
    end

    // Ready and valid toward the DUT change on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            ar_ready <= !rd_pend && beat_allowed(stall_pct_i);
            r_valid  <= rd_pend && (r_valid || beat_allowed(stall_pct_i));
            if (rd_pend) begin
                r_data <= peek(rd_addr);
            end
            aw_ready <= !aw_have && !b_pend && beat_allowed(stall_pct_i);
            w_ready  <= !w_have && !b_pend && beat_allowed(stall_pct_i);
            b_valid  <= b_pend && (b_valid || beat_allowed(stall_pct_i));
        end
    end

    assign arready_o = ar_ready;
    assign rvalid_o  = r_valid;
    assign rdata_o   = r_data;
    assign awready_o = aw_ready;
    assign wready_o  = w_ready;
    assign bvalid_o  = b_valid;

endmodule

`default_nettype wire

// ==== tb/mpdma_tb.sv ====
/*
 * Testbench for the matrix-padding DMA engine: clock and reset, a table
 * of runs applied in a loop, the mirror-rule reference and a watchdog
 */

`default_nettype none

`include "mpdma_cfg.svh"

module mpdma_tb;

    typedef struct {
        int               width;
        mpdma_pkg::addr_t src;
        mpdma_pkg::addr_t dst;
        int               stall_pct;
        bit               hold_start;   // Keep start_i high past done_o
    } row_t;

    localparam int NUM_ROWS = 6;

    logic                          clk;
    logic                          rst_n;
    mpdma_pkg::addr_t              src_addr;
    mpdma_pkg::addr_t              dst_addr;
    logic [`MPDMA_WIDTH_BITS-1:0]  mat_width;
    logic                          start;
    wire                           done;
    wire mpdma_pkg::addr_t         araddr;
    wire                           arvalid;
    wire                           arready;
    wire mpdma_pkg::data_t         rdata;
    wire                           rvalid;
    wire                           rready;
    wire mpdma_pkg::addr_t         awaddr;
    wire                           awvalid;
    wire                           awready;
    wire mpdma_pkg::data_t         wdata;
    wire                           wvalid;
    wire                           wready;
    wire                           bvalid;
    wire                           bready;
    int                            stall_pct;

    row_t             tests [NUM_ROWS];
    row_t             cur;
    mpdma_pkg::data_t src_snap [$];
    int               rd_count = 0;

    mpdma_top dut (
        .clk (clk), .rst_n (rst_n),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr),
        .mat_width_i (mat_width), .start_i (start), .done_o (done),
        .araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rvalid_i (rvalid), .rready_o (rready),
        .awaddr_o (awaddr), .awvalid_o (awvalid), .awready_i (awready),
        .wdata_o (wdata), .wvalid_o (wvalid), .wready_i (wready),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    mpdma_mem_model u_mem (
        .clk (clk), .rst_n (rst_n), .stall_pct_i (stall_pct),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rvalid_o (rvalid), .rready_i (rready),
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wvalid_i (wvalid), .wready_o (wready),
        .bvalid_o (bvalid), .bready_i (bready)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // Mirrored border: index 0 and W+1 reflect inward, the rest shift by one
    function automatic int source_index(input int k, input int w);
        if (k == 0) begin
            return 1;
        end else if (k == w + 1) begin
            return w - 2;
        end
        return k - 1;
    endfunction

    function automatic bit in_area(input mpdma_pkg::addr_t a, input mpdma_pkg::addr_t base,
                                   input int words);
        return (a >= base) && (a < base + mpdma_pkg::addr_t'(words * 4)) && (a[1:0] == 2'b00);
    endfunction

    task automatic load_tests();
        tests[0] = '{2,  32'h0000_1000, 32'h0000_8000, 0,  1'b0};
        tests[1] = '{8,  32'h2000_0000, 32'h3000_0000, 0,  1'b0};
        tests[2] = '{16, 32'h0001_0000, 32'h0004_0000, 0,  1'b1};
        tests[3] = '{8,  32'h0002_0100, 32'h0005_0000, 60, 1'b0};
        tests[4] = '{16, 32'h0010_0000, 32'h0020_0000, 60, 1'b0};
        tests[5] = '{62, 32'h0030_0000, 32'h0040_0000, 60, 1'b0};
    endtask

    // Walk blocks row-major, TL TR BL BR inside each, against the write log
    task automatic verify_row(input row_t t);
        int               span;
        int               n;
        int               r;
        int               c;
        mpdma_pkg::addr_t exp_addr;
        mpdma_pkg::data_t exp_data;
        span = t.width + 2;
        n = 0;
        check_value("number of writes", u_mem.log_size(), span * span);
        for (int br = 0; br <= t.width; br += 2) begin
            for (int bc = 0; bc <= t.width; bc += 2) begin
                for (int q = 0; q < 4; q++) begin
                    r = br + q / 2;
                    c = bc + q % 2;
                    exp_addr = t.dst + mpdma_pkg::addr_t'((r * span + c) * 4);
                    exp_data = src_snap[source_index(r, t.width) * t.width
                                        + source_index(c, t.width)];
                    check_value("write order address", u_mem.log_addr(n), exp_addr);
                    check_value("write order data", u_mem.log_data(n), exp_data);
                    check_value("destination word", u_mem.peek(exp_addr), exp_data);
                    n++;
                end
            end
        end
    endtask

    task automatic run_row(input row_t t);
        int reads_before;
        int reads_seen;
        cur = t;
        u_mem.fill_source(t.src, t.width);
        u_mem.clear_log();
        src_snap.delete();
        for (int i = 0; i < t.width * t.width; i++) begin
            src_snap.push_back(u_mem.peek(t.src + mpdma_pkg::addr_t'(i * 4)));
        end
        reads_before = rd_count;
        @(negedge clk);
        src_addr  = t.src;
        dst_addr  = t.dst;
        mat_width = `MPDMA_WIDTH_BITS'(t.width);
        stall_pct = t.stall_pct;
        start     = 1'b1;
        @(negedge clk);
        if (!t.hold_start) begin
            start = 1'b0;
        end
        check_value("done_o low after start", 32'(done), 32'd0);
        while (!done) begin
            @(negedge clk);
        end
        if (t.hold_start) begin  // A held start must not rerun the job
            reads_seen = rd_count;
            repeat (20) begin
                @(negedge clk);
                check_value("done_o while start held", 32'(done), 32'd1);
            end
            check_value("reads while start held", rd_count, reads_seen);
            start = 1'b0;
            @(negedge clk);
        end
        check_value("reads in run", rd_count - reads_before, (t.width + 2) * (t.width + 2));
        verify_row(t);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Bus address ranges for the row in progress
    always @(posedge clk) begin
        if (rst_n && arvalid && arready) begin
            rd_count <= rd_count + 1;
            check_value("read address inside source area",
                        32'(in_area(araddr, cur.src, cur.width * cur.width)), 32'd1);
        end
        if (rst_n && awvalid && awready) begin
            check_value("write address inside destination area",
                        32'(in_area(awaddr, cur.dst, (cur.width + 2) * (cur.width + 2))), 32'd1);
        end
    end

    initial begin
        int limit_cycles;
        @(posedge rst_n);
        limit_cycles = 100;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit_cycles += 40 * (tests[i].width + 2) * (tests[i].width + 2) + 100;
        end
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog: the runs did not finish within %0d cycles", limit_cycles);
        $display("Result: FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(18179));
        load_tests();
        cur       = tests[0];
        rst_n     = 1'b0;
        start     = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        mat_width = '0;
        stall_pct = 0;
        repeat (3) @(posedge clk);  // Three rising edges in reset
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("done_o after reset", 32'(done), 32'd1);
        check_value("arvalid_o after reset", 32'(arvalid), 32'd0);
        check_value("rready_o after reset", 32'(rready), 32'd0);
        check_value("awvalid_o after reset", 32'(awvalid), 32'd0);
        check_value("wvalid_o after reset", 32'(wvalid), 32'd0);
        check_value("bready_o after reset", 32'(bready), 32'd0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(tests[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
source/mpdma_pkg.sv
source/mpdma_job_if.sv
source/mpdma_word_if.sv
source/mpdma_block_walker.sv
source/mpdma_read_master.sv
source/mpdma_write_master.sv
source/mpdma_top.sv
tb/mpdma_mem_model.sv
tb/mpdma_tb.sv

// ==== Makefile ====
# Verilator flow for the matrix-padding DMA engine
# Override any variable from the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= mpdma_tb
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= mpdma_sim
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_BIN)

sim: build
	./$(OBJ_DIR)/$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "sim: pass message found in $(LOG)"; \
	else \
		echo "sim: pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
